// File: rtl/conv_out_wr_config.svh
`ifndef CONV_OUT_WR_CONFIG_SVH
`define CONV_OUT_WR_CONFIG_SVH

// bits per result feature
`define CONV_OUT_WR_FEATURE_W 16

// largest byte count of one write request
`define CONV_OUT_WR_MAX_BTT 2048

// largest INCR burst in beats
`define CONV_OUT_WR_MAX_BURST 32

// bursts allowed between commit and write response
`define CONV_OUT_WR_OUTSTANDING 4

// write-data buffer in 64-bit beats
// must hold at least one full burst
`define CONV_OUT_WR_WBUF_DEPTH 64

`endif

// File: rtl/conv_out_wr_pkg.sv
`include "conv_out_wr_config.svh"

package conv_out_wr_pkg;

	typedef logic [31:0] addr_t;      // byte address on the AXI bus
	typedef logic [11:0] btt_t;       // bytes of one request
	typedef logic [7:0]  axi_len_t;   // awlen encoding, beats minus one
	typedef logic [8:0]  beat_cnt_t;  // beats of a request minus one
	typedef logic [8:0]  page_cnt_t;  // beats left in the 4 KB page minus one

	typedef logic [63:0] wdata_t;
	typedef logic [7:0]  wstrb_t;
	typedef logic [`CONV_OUT_WR_FEATURE_W-1:0] feature_t;

	// first or last valid byte inside a beat
	typedef logic [2:0] byte_ofs_t;

	// burst planner, one burst every three cycles at best
	typedef enum logic [1:0] {
		WAIT_ROOM,  // wait for a request and an outstanding slot
		GEN_LEN,    // second pass through the shared comparator
		COMMIT      // burst goes into the table
	} plan_state_e;

endpackage

// File: rtl/sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wen_i,
	input  logic [WIDTH-1:0] din_i,
	output logic             full_n_o,
	input  logic             ren_i,
	output logic [WIDTH-1:0] dout_o,
	output logic             empty_n_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];  // storage ring
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [CNT_W-1:0] count;        // entries held
	logic             do_wr;
	logic             do_rd;

	assign full_n_o  = count != CNT_W'(DEPTH);
	assign empty_n_o = count != '0;
	assign dout_o    = mem[rptr];  // head word visible without a read
	assign do_wr     = wen_i & full_n_o;
	assign do_rd     = ren_i & empty_n_o;

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wptr] <= din_i;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;  // wrap at depth
			if (do_rd)
				rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			if (do_wr != do_rd)
				count <= do_wr ? count + 1'b1 : count - 1'b1;
		end
	end

	// producers look at full_n before they write
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wen_i |-> full_n_o)
		else $error("sync_fifo written while full");

endmodule

// File: rtl/burst_planner.sv
`include "conv_out_wr_config.svh"

module burst_planner (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [63:0]               req_data_i,  // {byte count, base address}
	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  logic                      info_full_n_i,
	output logic                      info_wen_o,
	output logic [5:0]                info_din_o,  // {first ofs, last ofs}
	input  logic                      room_i,
	output logic                      launch_o,
	output logic                      launch_last_o,
	output conv_out_wr_pkg::axi_len_t burst_len_o,
	output logic                      burst_avail_o,
	input  logic                      burst_filled_i,
	output conv_out_wr_pkg::addr_t    awaddr_o,
	output conv_out_wr_pkg::axi_len_t awlen_o,
	output logic                      awvalid_o,
	input  logic                      awready_i
);
	localparam int OUTS  = `CONV_OUT_WR_OUTSTANDING;
	localparam int PTR_W = (OUTS > 1) ? $clog2(OUTS) : 1;
	localparam conv_out_wr_pkg::page_cnt_t MAX_LEN =
		conv_out_wr_pkg::page_cnt_t'(`CONV_OUT_WR_MAX_BURST - 1);

	conv_out_wr_pkg::btt_t        btt;
	conv_out_wr_pkg::addr_t       base;
	logic [12:0]                  end_ofs;     // byte count plus start misalignment
	logic [12:0]                  end_m1;      // offset of the final byte
	logic                         req_idle;
	logic                         accept;
	conv_out_wr_pkg::plan_state_e state;
	conv_out_wr_pkg::addr_t       cur_addr;    // 8-byte aligned
	conv_out_wr_pkg::beat_cnt_t   beats_left;
	conv_out_wr_pkg::page_cnt_t   page_left;
	conv_out_wr_pkg::page_cnt_t   cmp_a;       // shared comparator
	conv_out_wr_pkg::page_cnt_t   cmp_b;
	logic                         cmp_le;
	conv_out_wr_pkg::axi_len_t    min_len;
	logic                         last_burst;
	logic                         commit;
	logic                         fill;
	logic                         issue;
	conv_out_wr_pkg::addr_t       tb_addr [OUTS];
	conv_out_wr_pkg::axi_len_t    tb_len  [OUTS];
	logic [1:0]                   tb_flag [OUTS];  // 00 free, 01 planned, 11 data ready
	logic [PTR_W-1:0]             wr_ptr;
	logic [PTR_W-1:0]             fill_ptr;
	logic [PTR_W-1:0]             iss_ptr;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(OUTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign btt     = req_data_i[32 +: 12];
	assign base    = req_data_i[31:0];
	assign end_ofs = {1'b0, btt} + 13'(base[2:0]);
	assign end_m1  = end_ofs - 13'd1;

	assign req_ready_o = req_idle & info_full_n_i;
	assign accept      = req_valid_i & req_ready_o;
	assign info_wen_o  = accept;
	assign info_din_o  = {base[2:0], end_m1[2:0]};

	// first pass page vs max burst, second pass remaining vs that minimum
	assign cmp_a  = (state == conv_out_wr_pkg::WAIT_ROOM) ? page_left : beats_left;
	assign cmp_b  = (state == conv_out_wr_pkg::WAIT_ROOM) ? MAX_LEN : {1'b0, min_len};
	assign cmp_le = cmp_a <= cmp_b;

	assign commit        = (state == conv_out_wr_pkg::COMMIT) & (tb_flag[wr_ptr] == 2'b00);
	assign launch_o      = commit;
	assign launch_last_o = last_burst;

	assign burst_avail_o = tb_flag[fill_ptr] == 2'b01;  // next burst still owed data
	assign burst_len_o   = tb_len[fill_ptr];
	assign fill          = burst_filled_i & burst_avail_o;

	assign awvalid_o = tb_flag[iss_ptr] == 2'b11;
	assign awaddr_o  = tb_addr[iss_ptr];
	assign awlen_o   = tb_len[iss_ptr];
	assign issue     = awvalid_o & awready_i;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= conv_out_wr_pkg::WAIT_ROOM;
			req_idle <= 1'b1;
		end
		else
		begin
			if (accept)
				req_idle <= 1'b0;
			else if (commit & last_burst)
				req_idle <= 1'b1;  // request fully planned
			case (state)
				conv_out_wr_pkg::WAIT_ROOM:
					if (room_i & ~req_idle)
						state <= conv_out_wr_pkg::GEN_LEN;
				conv_out_wr_pkg::GEN_LEN:
					state <= conv_out_wr_pkg::COMMIT;
				conv_out_wr_pkg::COMMIT:
					if (commit)
						state <= conv_out_wr_pkg::WAIT_ROOM;
				default:
					state <= conv_out_wr_pkg::WAIT_ROOM;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == conv_out_wr_pkg::WAIT_ROOM) | (state == conv_out_wr_pkg::GEN_LEN))
			min_len <= cmp_le ? cmp_a[7:0] : cmp_b[7:0];
		if (state == conv_out_wr_pkg::GEN_LEN)
			last_burst <= cmp_le;  // remaining beats fit this burst
		if (accept)
		begin
			cur_addr   <= {base[31:3], 3'b000};
			beats_left <= end_m1[11:3];
			page_left  <= ~base[11:3];  // 511 minus beat index in page
		end
		else if (commit)
		begin
			cur_addr   <= {cur_addr[31:3] + 29'(min_len) + 29'd1, 3'b000};
			beats_left <= beats_left - 9'(min_len) - 9'd1;
			page_left  <= page_left - 9'(min_len) - 9'd1;  // wraps to 511 on a new page
		end
		if (commit)
		begin
			tb_addr[wr_ptr] <= cur_addr;
			tb_len[wr_ptr]  <= min_len;
		end
	end

	// entry life cycle planned, data ready, issued
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < OUTS; i++)
				tb_flag[i] <= 2'b00;
			wr_ptr   <= '0;
			fill_ptr <= '0;
			iss_ptr  <= '0;
		end
		else
		begin
			if (commit)
			begin
				tb_flag[wr_ptr] <= 2'b01;
				wr_ptr          <= ptr_inc(wr_ptr);
			end
			if (fill)
			begin
				tb_flag[fill_ptr] <= 2'b11;
				fill_ptr          <= ptr_inc(fill_ptr);
			end
			if (issue)
			begin
				tb_flag[iss_ptr] <= 2'b00;
				iss_ptr          <= ptr_inc(iss_ptr);
			end
		end
	end

	a_no_4k_cross: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid_o |-> ({1'b0, awaddr_o[11:3]} + 10'(awlen_o)) <= 10'd511)
		else $error("burst crosses a 4 KB boundary");

endmodule

// File: rtl/feature_packer.sv
`include "conv_out_wr_config.svh"

module feature_packer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  conv_out_wr_pkg::feature_t res_data_i,
	input  logic                      res_last_i,
	input  logic                      res_valid_i,
	output logic                      res_ready_o,
	input  logic [5:0]                info_dout_i,  // {first ofs, last ofs}
	input  logic                      info_empty_n_i,
	output logic                      info_ren_o,
	input  conv_out_wr_pkg::axi_len_t burst_len_i,
	input  logic                      burst_avail_i,
	output logic                      burst_filled_o,
	input  logic                      buf_full_n_i,
	output logic                      buf_wen_o,
	output logic [72:0]               buf_din_o     // {data, strobe, last}
);
	localparam int FW     = `CONV_OUT_WR_FEATURE_W;
	localparam int LANES  = 64 / FW;
	localparam int LANE_B = FW / 8;  // bytes per lane

	conv_out_wr_pkg::byte_ofs_t first_ofs;
	conv_out_wr_pkg::byte_ofs_t last_ofs;
	conv_out_wr_pkg::wstrb_t    first_strb;
	conv_out_wr_pkg::wstrb_t    last_strb;
	logic [LANES-1:0]           first_vec;  // lane of the first feature
	logic [LANES-1:0]           lane_q;
	logic [LANES-1:0]           lane_cur;   // one-hot write lane
	logic                       first_feat;
	logic                       first_beat;
	conv_out_wr_pkg::feature_t  lanes [LANES];
	conv_out_wr_pkg::wdata_t    beat_data;
	conv_out_wr_pkg::axi_len_t  beat_idx;   // beat inside current burst
	logic                       burst_end;
	logic                       beat_done;
	logic                       stage_rdy;
	logic                       accept;
	logic                       push;       // beat moves into output stage
	conv_out_wr_pkg::wdata_t    out_data;
	conv_out_wr_pkg::wstrb_t    out_strb;
	logic                       out_last;
	logic                       out_valid;

	assign {first_ofs, last_ofs} = info_dout_i;
	assign first_strb = 8'hff << first_ofs;           // drop bytes below start
	assign last_strb  = 8'hff >> (3'd7 - last_ofs);   // drop bytes past end
	assign first_vec  = LANES'(1) << (first_ofs / LANE_B);
	assign lane_cur   = first_feat ? first_vec : lane_q;

	assign burst_end = beat_idx == burst_len_i;
	assign beat_done = lane_cur[LANES-1] | res_last_i;  // top lane or end of request
	assign stage_rdy = ~out_valid | buf_full_n_i;

	// only the closing feature of a beat waits on the output stage
	assign res_ready_o = info_empty_n_i & burst_avail_i & (~beat_done | stage_rdy);
	assign accept      = res_valid_i & res_ready_o;
	assign push        = accept & beat_done;

	assign info_ren_o     = accept & res_last_i;
	assign burst_filled_o = push & burst_end;
	assign buf_wen_o      = out_valid & buf_full_n_i;
	assign buf_din_o      = {out_data, out_strb, out_last};

	// current feature bypasses into its lane
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			beat_data[i*FW +: FW] = lane_cur[i] ? res_data_i : lanes[i];
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			for (int i = 0; i < LANES; i++)
				if (lane_cur[i])
					lanes[i] <= res_data_i;
		end
		if (push)
		begin
			out_data <= beat_data;
			out_strb <= (first_beat ? first_strb : 8'hff) & (res_last_i ? last_strb : 8'hff);
			out_last <= burst_end;  // wlast
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			first_feat <= 1'b1;
			first_beat <= 1'b1;
			lane_q     <= '0;
			beat_idx   <= '0;
			out_valid  <= 1'b0;
		end
		else
		begin
			if (accept)
			begin
				first_feat <= res_last_i;
				lane_q     <= {lane_cur[LANES-2:0], lane_cur[LANES-1]};  // rotate up
			end
			if (push)
			begin
				first_beat <= res_last_i;
				beat_idx   <= burst_end ? '0 : beat_idx + 8'd1;
			end
			if (stage_rdy)
				out_valid <= push;
		end
	end

	// byte count of the request and the feature stream must agree
	a_last_on_burst_end: assert property (@(posedge clk) disable iff (!rst_n)
		accept & res_last_i |-> burst_end)
		else $error("final feature before the final beat of the burst");

endmodule

// File: rtl/outstanding_tracker.sv
`include "conv_out_wr_config.svh"

module outstanding_tracker (
	input  logic clk,
	input  logic rst_n,
	input  logic launch_i,       // burst committed
	input  logic launch_last_i,  // it closes its request
	input  logic bvalid_i,
	output logic room_o,
	output logic wt_req_fns_o
);
	localparam int OUTS  = `CONV_OUT_WR_OUTSTANDING;
	localparam int PTR_W = (OUTS > 1) ? $clog2(OUTS) : 1;
	localparam int CNT_W = $clog2(OUTS + 1);

	logic [CNT_W-1:0] in_flight;
	logic             fin_q [OUTS];  // final-burst flag per burst in flight
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;

	assign room_o       = in_flight != CNT_W'(OUTS);
	assign wt_req_fns_o = bvalid_i & fin_q[rptr];  // same cycle as the response

	always_ff @(posedge clk)
	begin
		if (launch_i)
			fin_q[wptr] <= launch_last_i;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			in_flight <= '0;
			wptr      <= '0;
			rptr      <= '0;
		end
		else
		begin
			if (launch_i != bvalid_i)
				in_flight <= bvalid_i ? in_flight - 1'b1 : in_flight + 1'b1;
			if (launch_i)
				wptr <= (wptr == PTR_W'(OUTS - 1)) ? '0 : wptr + 1'b1;
			if (bvalid_i)
				rptr <= (rptr == PTR_W'(OUTS - 1)) ? '0 : rptr + 1'b1;
		end
	end

	// responses come only for addresses the planner sent
	a_no_stray_b: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid_i |-> in_flight != '0)
		else $error("write response with no burst in flight");

endmodule

// File: rtl/conv_out_wr_top.sv
`include "conv_out_wr_config.svh"

module conv_out_wr_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [63:0]               req_data_i,  // {byte count, base address}
	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  conv_out_wr_pkg::feature_t res_data_i,
	input  logic                      res_last_i,
	input  logic                      res_valid_i,
	output logic                      res_ready_o,
	output conv_out_wr_pkg::addr_t    awaddr_o,
	output logic [1:0]                awburst_o,
	output conv_out_wr_pkg::axi_len_t awlen_o,
	output logic [2:0]                awsize_o,
	output logic                      awvalid_o,
	input  logic                      awready_i,
	output conv_out_wr_pkg::wdata_t   wdata_o,
	output conv_out_wr_pkg::wstrb_t   wstrb_o,
	output logic                      wlast_o,
	output logic                      wvalid_o,
	input  logic                      wready_i,
	input  logic                      bvalid_i,
	output logic                      bready_o,
	output logic                      wt_req_fns_o
);
	logic                      info_wen;
	logic [5:0]                info_din;
	logic                      info_full_n;
	logic                      info_ren;
	logic [5:0]                info_dout;
	logic                      info_empty_n;
	logic                      room;
	logic                      launch;
	logic                      launch_last;
	conv_out_wr_pkg::axi_len_t burst_len;
	logic                      burst_avail;
	logic                      burst_filled;
	logic                      buf_wen;
	logic [72:0]               buf_din;
	logic                      buf_full_n;
	logic [72:0]               buf_dout;

	assign awburst_o = 2'b01;   // INCR
	assign awsize_o  = 3'b011;  // 8 bytes per beat
	assign bready_o  = 1'b1;
	assign {wdata_o, wstrb_o, wlast_o} = buf_dout;

	burst_planner planner_i (
		.clk, .rst_n,
		.req_data_i, .req_valid_i, .req_ready_o,
		.info_full_n_i(info_full_n), .info_wen_o(info_wen), .info_din_o(info_din),
		.room_i(room), .launch_o(launch), .launch_last_o(launch_last),
		.burst_len_o(burst_len), .burst_avail_o(burst_avail), .burst_filled_i(burst_filled),
		.awaddr_o, .awlen_o, .awvalid_o, .awready_i
	);

	// start and end offsets of queued requests
	sync_fifo #(.WIDTH(6), .DEPTH(3)) info_fifo (
		.clk, .rst_n,
		.wen_i(info_wen), .din_i(info_din), .full_n_o(info_full_n),
		.ren_i(info_ren), .dout_o(info_dout), .empty_n_o(info_empty_n)
	);

	feature_packer packer_i (
		.clk, .rst_n,
		.res_data_i, .res_last_i, .res_valid_i, .res_ready_o,
		.info_dout_i(info_dout), .info_empty_n_i(info_empty_n), .info_ren_o(info_ren),
		.burst_len_i(burst_len), .burst_avail_i(burst_avail), .burst_filled_o(burst_filled),
		.buf_full_n_i(buf_full_n), .buf_wen_o(buf_wen), .buf_din_o(buf_din)
	);

	// w channel straight off the buffer head
	sync_fifo #(.WIDTH(73), .DEPTH(`CONV_OUT_WR_WBUF_DEPTH)) wbuf_fifo (
		.clk, .rst_n,
		.wen_i(buf_wen), .din_i(buf_din), .full_n_o(buf_full_n),
		.ren_i(wready_i), .dout_o(buf_dout), .empty_n_o(wvalid_o)
	);

	outstanding_tracker tracker_i (
		.clk, .rst_n,
		.launch_i(launch), .launch_last_i(launch_last), .bvalid_i,
		.room_o(room), .wt_req_fns_o
	);

endmodule

// File: testbench/conv_out_wr_tests.svh
`ifndef CONV_OUT_WR_TESTS_SVH
`define CONV_OUT_WR_TESTS_SVH

	// one request for each of tests 1 to 4, the last three for test 5
	localparam int NUM_REQ = 7;
	localparam conv_out_wr_pkg::addr_t REQ_BASE [NUM_REQ] =
		'{32'h1000, 32'h2006, 32'h3000, 32'h4F80, 32'h6002, 32'h6FF0, 32'h8004};
	localparam int REQ_BTT [NUM_REQ] = '{64, 20, 600, 512, 300, 1000, 2044};

	// expected traffic of the running test
	conv_out_wr_pkg::addr_t    exp_aw_addr [$];
	conv_out_wr_pkg::axi_len_t exp_aw_len [$];
	conv_out_wr_pkg::wdata_t   exp_w_data [$];  // unstrobed bytes zero
	conv_out_wr_pkg::wstrb_t   exp_w_strb [$];
	logic                      exp_w_last [$];

	// start misalignment plus byte count, rounded up to beats
	function automatic int beats_of(input int req);
		return (int'(REQ_BASE[req][2:0]) + REQ_BTT[req] + 7) / 8;
	endfunction

	function automatic int watchdog_cycles();
		int beats;
		beats = 0;
		for (int r = 0; r < NUM_REQ; r++)
			beats += beats_of(r);
		return beats * BEAT_CYCLES;
	endfunction

	// request number in the top nibble, feature index below
	function automatic conv_out_wr_pkg::feature_t feature_val(input int req, input int k);
		return conv_out_wr_pkg::feature_t'(((req + 1) << 12) + (k % 4096));
	endfunction

	function automatic logic [7:0] byte_of(input int req, input int ofs);
		conv_out_wr_pkg::feature_t f;
		f = feature_val(req, ofs / 2);
		return (ofs % 2 == 1) ? f[15:8] : f[7:0];  // little endian lanes
	endfunction

	task automatic predict(input int req);
		conv_out_wr_pkg::addr_t  addr;
		conv_out_wr_pkg::wdata_t data;
		conv_out_wr_pkg::wstrb_t strb;
		int ofs;
		int rem;
		int len;
		int beat;
		int pos;
		ofs  = int'(REQ_BASE[req][2:0]);
		addr = {REQ_BASE[req][31:3], 3'b000};
		rem  = beats_of(req);
		beat = 0;
		while (rem > 0)
		begin
			// smallest of remainder, burst limit and beats to the 4 KB page end
			len = rem;
			if (len > `CONV_OUT_WR_MAX_BURST)
				len = `CONV_OUT_WR_MAX_BURST;
			if (len > (4096 - int'(addr[11:0])) / 8)
				len = (4096 - int'(addr[11:0])) / 8;
			exp_aw_addr.push_back(addr);
			exp_aw_len.push_back(conv_out_wr_pkg::axi_len_t'(len - 1));
			for (int i = 0; i < len; i++)
			begin
				data = '0;
				strb = '0;
				for (int j = 0; j < 8; j++)
				begin
					pos = beat * 8 + j - ofs;  // byte index inside the request
					if (pos >= 0 && pos < REQ_BTT[req])
					begin
						strb[j]        = 1'b1;
						data[j*8 +: 8] = byte_of(req, pos);
					end
				end
				exp_w_data.push_back(data);
				exp_w_strb.push_back(strb);
				exp_w_last.push_back(i == len - 1);
				beat++;
			end
			addr = addr + conv_out_wr_pkg::addr_t'(len * 8);
			rem  = rem - len;
		end
	endtask

	task automatic send_requests(input int first, input int count);
		for (int r = first; r < first + count; r++)
		begin
			req_data  = {32'(REQ_BTT[r]), REQ_BASE[r]};
			req_valid = 1'b1;
			@(posedge clk);
			while (!req_ready)
				@(posedge clk);
			#(DRIVE_DLY);
		end
		req_valid = 1'b0;
	endtask

	task automatic send_features(input int first, input int count);
		for (int r = first; r < first + count; r++)
		begin
			for (int k = 0; k < REQ_BTT[r] / 2; k++)
			begin
				res_data  = feature_val(r, k);
				res_last  = (k == REQ_BTT[r] / 2 - 1);
				res_valid = 1'b1;
				@(posedge clk);
				while (!res_ready)
					@(posedge clk);
				#(DRIVE_DLY);
			end
		end
		res_valid = 1'b0;
		res_last  = 1'b0;
	endtask

	task automatic wait_done(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (done_cnt < target && cycles < limit)
		begin
			@(posedge clk);
			#(DRIVE_DLY);
			cycles++;
		end
		if (done_cnt < target)
		begin
			err_cnt++;
			$display("t=%0t done pulse missing after %0d cycles", $time, limit);
		end
		repeat (20)  // room for a stray extra pulse
		begin
			@(posedge clk);
			#(DRIVE_DLY);
		end
	endtask

	task automatic compare_results(input int aw_base, input int w_base);
		conv_out_wr_pkg::wdata_t mask;
		check_count("aw bursts", got_aw_addr.size() - aw_base, exp_aw_addr.size());
		check_count("w beats", got_w_data.size() - w_base, exp_w_data.size());
		foreach (exp_aw_addr[i])
		begin
			if (aw_base + i < got_aw_addr.size())
			begin
				check_addr($sformatf("awaddr[%0d]", i), got_aw_addr[aw_base + i],
					exp_aw_addr[i]);
				check_len($sformatf("awlen[%0d]", i), got_aw_len[aw_base + i], exp_aw_len[i]);
				check_count("awburst", int'(got_aw_burst[aw_base + i]), 1);  // INCR
				check_count("awsize", int'(got_aw_size[aw_base + i]), 3);    // 8 bytes
			end
		end
		foreach (exp_w_data[i])
		begin
			if (w_base + i < got_w_data.size())
			begin
				for (int j = 0; j < 8; j++)
					mask[j*8 +: 8] = {8{exp_w_strb[i][j]}};
				check_strb($sformatf("wstrb[%0d]", i), got_w_strb[w_base + i], exp_w_strb[i]);
				check_data($sformatf("wdata[%0d]", i), got_w_data[w_base + i] & mask,
					exp_w_data[i]);
				check_flag($sformatf("wlast[%0d]", i), got_w_last[w_base + i], exp_w_last[i]);
			end
		end
	endtask

	// requests first to first+count-1, end to end
	task automatic run_traffic(input int first, input int count);
		int aw_base;
		int w_base;
		int done_base;
		int beats;
		exp_aw_addr.delete();
		exp_aw_len.delete();
		exp_w_data.delete();
		exp_w_strb.delete();
		exp_w_last.delete();
		aw_base   = got_aw_addr.size();
		w_base    = got_w_data.size();
		done_base = done_cnt;
		beats     = 0;
		for (int r = first; r < first + count; r++)
		begin
			predict(r);
			beats += beats_of(r);
		end
		fork
			send_requests(first, count);
			send_features(first, count);  // own thread, planning can wait on data
			wait_done(done_base + count, beats * BEAT_CYCLES);
		join
		compare_results(aw_base, w_base);
		check_count("done pulses", done_cnt - done_base, count);
	endtask

	task automatic report_test(input int num, input string name, input int err_base);
		if (err_cnt == err_base)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, err_cnt - err_base);
	endtask

	task automatic test_aligned();
		int err_base;
		err_base = err_cnt;
		run_traffic(0, 1);
		report_test(1, "aligned request", err_base);
	endtask

	task automatic test_unaligned();
		int err_base;
		int n;
		err_base = err_cnt;
		run_traffic(1, 1);
		n = got_w_strb.size();
		// start at byte 6, end at byte 1 of the fourth beat
		check_strb("first wstrb", got_w_strb[n - 4], 8'hC0);
		check_strb("last wstrb", got_w_strb[n - 1], 8'h03);
		report_test(2, "unaligned request", err_base);
	endtask

	task automatic test_length_split();
		int err_base;
		err_base = err_cnt;
		run_traffic(2, 1);  // 32, 32, 11 beats
		report_test(3, "length split", err_base);
	endtask

	task automatic test_page_cross();
		int err_base;
		err_base = err_cnt;
		run_traffic(3, 1);  // 16, 32, 16 beats around 0x5000
		report_test(4, "page crossing", err_base);
	endtask

	task automatic test_backpressure();
		int err_base;
		err_base   = err_cnt;
		use_random = 1'b1;
		run_traffic(4, 3);
		use_random = 1'b0;
		report_test(5, "back-pressure and queueing", err_base);
	endtask

`endif

// File: testbench/conv_out_wr_tb.sv
`include "conv_out_wr_config.svh"

module conv_out_wr_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DLY   = 10;  // input skew after the rising edge
	localparam int BEAT_CYCLES = 40;  // time budget per expected beat

	logic                      clk;
	logic                      rst_n;
	logic [63:0]               req_data;
	logic                      req_valid;
	logic                      req_ready;
	conv_out_wr_pkg::feature_t res_data;
	logic                      res_last;
	logic                      res_valid;
	logic                      res_ready;
	conv_out_wr_pkg::addr_t    awaddr;
	logic [1:0]                awburst;
	conv_out_wr_pkg::axi_len_t awlen;
	logic [2:0]                awsize;
	logic                      awvalid;
	logic                      awready = 1'b1;
	conv_out_wr_pkg::wdata_t   wdata;
	conv_out_wr_pkg::wstrb_t   wstrb;
	logic                      wlast;
	logic                      wvalid;
	logic                      wready = 1'b1;
	logic                      bvalid = 1'b0;
	logic                      bready;
	logic                      done;

	// traffic seen by the slave, kept for the whole run
	conv_out_wr_pkg::addr_t    got_aw_addr [$];
	conv_out_wr_pkg::axi_len_t got_aw_len [$];
	logic [1:0]                got_aw_burst [$];
	logic [2:0]                got_aw_size [$];
	conv_out_wr_pkg::wdata_t   got_w_data [$];
	conv_out_wr_pkg::wstrb_t   got_w_strb [$];
	logic                      got_w_last [$];

	int          aw_cnt = 0;
	int          wlast_cnt = 0;
	int          b_cnt = 0;     // responses sent
	int          done_cnt = 0;
	int          chk_cnt = 0;
	int          err_cnt = 0;
	logic        use_random = 1'b0;  // ready throttling on or off
	logic [31:0] lfsr_q = 32'd73804;

	conv_out_wr_top dut_i (
		.clk,
		.rst_n,
		.req_data_i(req_data),
		.req_valid_i(req_valid),
		.req_ready_o(req_ready),
		.res_data_i(res_data),
		.res_last_i(res_last),
		.res_valid_i(res_valid),
		.res_ready_o(res_ready),
		.awaddr_o(awaddr),
		.awburst_o(awburst),
		.awlen_o(awlen),
		.awsize_o(awsize),
		.awvalid_o(awvalid),
		.awready_i(awready),
		.wdata_o(wdata),
		.wstrb_o(wstrb),
		.wlast_o(wlast),
		.wvalid_o(wvalid),
		.wready_i(wready),
		.bvalid_i(bvalid),
		.bready_o(bready),
		.wt_req_fns_o(done)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic ready_bit();
		if (!use_random)
			return 1'b1;
		lfsr_q = lfsr_step(lfsr_q);  // one step per bit taken
		return lfsr_q[0];
	endfunction

	task automatic mismatch(input string name, input string got, input string exp);
		err_cnt++;
		$display("MISMATCH t=%0t %s got %s exp %s", $time, name, got, exp);
	endtask

	task automatic check_addr(input string name, input conv_out_wr_pkg::addr_t got,
		input conv_out_wr_pkg::addr_t exp);
		chk_cnt++;
		if (got !== exp)
			mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_len(input string name, input conv_out_wr_pkg::axi_len_t got,
		input conv_out_wr_pkg::axi_len_t exp);
		chk_cnt++;
		if (got !== exp)
			mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic check_data(input string name, input conv_out_wr_pkg::wdata_t got,
		input conv_out_wr_pkg::wdata_t exp);
		chk_cnt++;
		if (got !== exp)
			mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_strb(input string name, input conv_out_wr_pkg::wstrb_t got,
		input conv_out_wr_pkg::wstrb_t exp);
		chk_cnt++;
		if (got !== exp)
			mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		chk_cnt++;
		if (got !== exp)
			mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		chk_cnt++;
		if (got != exp)
			mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	`include "conv_out_wr_tests.svh"

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// AXI slave, records AW and W, one response per completed burst
	always @(posedge clk)
	begin
		if (awvalid && awready)
		begin
			got_aw_addr.push_back(awaddr);
			got_aw_len.push_back(awlen);
			got_aw_burst.push_back(awburst);
			got_aw_size.push_back(awsize);
			aw_cnt++;
		end
		if (wvalid && wready)
		begin
			got_w_data.push_back(wdata);
			got_w_strb.push_back(wstrb);
			got_w_last.push_back(wlast);
			if (wlast)
				wlast_cnt++;
		end
		if (bvalid)
		begin
			check_flag("bready", bready, 1'b1);  // master takes every response
			b_cnt++;
		end
		if (done)
			done_cnt++;
		#(DRIVE_DLY);
		bvalid  = (b_cnt < aw_cnt) && (b_cnt < wlast_cnt);  // needs address and wlast
		awready = ready_bit();
		wready  = ready_bit();
	end

	initial
	begin
		rst_n     = 1'b0;
		req_data  = '0;
		req_valid = 1'b0;
		res_data  = '0;
		res_last  = 1'b0;
		res_valid = 1'b0;
		repeat (3) @(posedge clk);
		#(DRIVE_DLY);
		rst_n = 1'b1;
		@(posedge clk);
		#(DRIVE_DLY);
		check_flag("req_ready after reset", req_ready, 1'b1);
		check_flag("res_ready after reset", res_ready, 1'b0);
		check_flag("awvalid after reset", awvalid, 1'b0);
		check_flag("wvalid after reset", wvalid, 1'b0);
		check_flag("wt_req_fns after reset", done, 1'b0);
		test_aligned();
		test_unaligned();
		test_length_split();
		test_page_cross();
		test_backpressure();
		$display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// upper bound on run time from the beats of all tests
	initial
	begin
		#(watchdog_cycles() * CLK_PERIOD);
		$display("t=%0t watchdog expired, the DUT stopped making progress", $time);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+rtl
+incdir+testbench
rtl/conv_out_wr_pkg.sv
rtl/sync_fifo.sv
rtl/burst_planner.sv
rtl/feature_packer.sv
rtl/outstanding_tracker.sv
rtl/conv_out_wr_top.sv
testbench/conv_out_wr_tb.sv

// File: Makefile
# Verilator flow for the convolution write channel
VERILATOR ?= verilator
TOP       ?= conv_out_wr_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
